//--- sources.f
+incdir+dv
source/lsu_fwd_pkg.sv
source/lsu_stage_if.sv
source/lsu_lane_gen.sv
source/lsu_pipe_ctrl.sv
source/lsu_fwd_match.sv
source/lsu_fwd_merge.sv
source/lsu_fwd_top.sv
dv/lsu_fwd_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
TOP         = lsu_fwd_tb
RTL_TOP     = lsu_fwd_top
FILELIST    = sources.f
OBJ_DIR     = obj_dir
LOG         = sim.log
PASS_MSG    = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/lsu_fwd_vectors.svh
/* forwarding test vectors */

`ifndef LSU_FWD_VECTORS_SVH
`define LSU_FWD_VECTORS_SVH

// columns: behavior, store size, store addr, store data, random data,
// second is load, second size, second addr, flush store, side effects, full hit
localparam int n_vec = 23;

localparam vec_t vectors [n_vec] = '{
   // aligned and covered loads
   '{4'd2, size_word, 32'h100, 32'hdeadbeef, 1'b0, 1'b1, size_word, 32'h100, 1'b0, 1'b0, 1'b1},
   '{4'd2, size_word, 32'h2000, 32'h0, 1'b1, 1'b1, size_word, 32'h2000, 1'b0, 1'b0, 1'b1},
   '{4'd2, size_word, 32'h104, 32'h0, 1'b1, 1'b1, size_half, 32'h106, 1'b0, 1'b0, 1'b1},
   '{4'd2, size_word, 32'h108, 32'h87654321, 1'b0, 1'b1, size_byte, 32'h10b, 1'b0, 1'b0, 1'b1},
   '{4'd2, size_byte, 32'h300, 32'h0, 1'b1, 1'b1, size_byte, 32'h300, 1'b0, 1'b0, 1'b1},

   // partial cover, rest reads zero
   '{4'd3, size_byte, 32'h201, 32'h000000a5, 1'b0, 1'b1, size_word, 32'h200, 1'b0, 1'b0, 1'b0},
   '{4'd3, size_half, 32'h202, 32'h0, 1'b1, 1'b1, size_word, 32'h200, 1'b0, 1'b0, 1'b0},
   '{4'd3, size_byte, 32'h213, 32'h11223344, 1'b0, 1'b1, size_half, 32'h212, 1'b0, 1'b0, 1'b0},

   // word crossing stores and loads
   '{4'd4, size_word, 32'h402, 32'h0, 1'b1, 1'b1, size_word, 32'h404, 1'b0, 1'b0, 1'b0},
   '{4'd4, size_word, 32'h402, 32'h0, 1'b1, 1'b1, size_half, 32'h404, 1'b0, 1'b0, 1'b1},
   '{4'd4, size_word, 32'h503, 32'h0, 1'b1, 1'b1, size_word, 32'h503, 1'b0, 1'b0, 1'b1},
   '{4'd4, size_half, 32'h603, 32'hcafef00d, 1'b0, 1'b1, size_word, 32'h601, 1'b0, 1'b0, 1'b0},
   '{4'd4, size_word, 32'h700, 32'h0, 1'b1, 1'b1, size_word, 32'h6fe, 1'b0, 1'b0, 1'b0},
   '{4'd4, size_word, 32'h6fe, 32'h0, 1'b1, 1'b1, size_half, 32'h700, 1'b0, 1'b0, 1'b1},
   '{4'd4, size_half, 32'h7ff, 32'h0000beef, 1'b0, 1'b1, size_half, 32'h7ff, 1'b0, 1'b0, 1'b1},

   // flush and side effects
   '{4'd5, size_word, 32'h900, 32'h0badcafe, 1'b0, 1'b1, size_word, 32'h900, 1'b1, 1'b0, 1'b0},
   '{4'd5, size_word, 32'h904, 32'h0, 1'b1, 1'b1, size_word, 32'h904, 1'b0, 1'b1, 1'b0},
   '{4'd5, size_byte, 32'h908, 32'h0000005a, 1'b0, 1'b1, size_byte, 32'h908, 1'b1, 1'b0, 1'b0},

   // merge hints, store then store and store then load
   '{4'd6, size_word, 32'ha00, 32'h0, 1'b1, 1'b0, size_word, 32'ha04, 1'b0, 1'b0, 1'b0},
   '{4'd6, size_word, 32'ha00, 32'h0, 1'b1, 1'b0, size_word, 32'ha00, 1'b0, 1'b0, 1'b0},
   '{4'd6, size_word, 32'ha00, 32'h0, 1'b1, 1'b0, size_word, 32'hb08, 1'b0, 1'b0, 1'b0},
   '{4'd6, size_word, 32'ha06, 32'h0, 1'b1, 1'b0, size_word, 32'ha08, 1'b0, 1'b0, 1'b0},
   '{4'd6, size_word, 32'hc00, 32'h0, 1'b1, 1'b1, size_word, 32'hc40, 1'b0, 1'b0, 1'b0}
};

`endif

//--- dv/lsu_fwd_tb.sv
/* lsu forwarding testbench */

module lsu_fwd_tb;
   import lsu_fwd_pkg::*;

   // one store followed by one younger access
   typedef struct packed {
      logic [3:0]        beh;        // behavior group
      logic [size_w-1:0] st_size;
      logic [addr_w-1:0] st_addr;
      logic [data_w-1:0] st_data;
      logic              rnd;        // random store data
      logic              m_load;     // second access is a load, else a store
      logic [size_w-1:0] m_size;
      logic [addr_w-1:0] m_addr;
      logic              flush;      // store is flushed in M
      logic              side_eff;   // second access has side effects
      logic              exp_full;
   } vec_t;

   `include "lsu_fwd_vectors.svh"

   logic              clk;
   logic              arst_n;
   logic              busreq_m;
   logic              valid_m;
   logic              load_m;
   logic              store_m;
   logic [size_w-1:0] size_m;
   logic [addr_w-1:0] addr_m;
   logic              is_sideeffects_m;
   logic              flush_m;
   logic [data_w-1:0] store_data_r;
   logic              busreq_r;
   logic [data_w-1:0] bus_read_data_m;
   logic              ld_full_hit_m;
   logic              no_word_merge_r;
   logic              no_dword_merge_r;

   int                errors;
   int                checks;
   int                bad_tests;
   int                wait_cnt;
   logic              row_bad;

   lsu_fwd_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ******************************
   // reference model
   // ******************************
   function automatic int unsigned access_bytes(input logic [size_w-1:0] size);
      case (size)
         size_byte: return 1;
         size_half: return 2;
         default:   return 4;
      endcase
   endfunction

   // walk the requested byte addresses and pick each one the store wrote
   function automatic logic [data_w-1:0] expected_data(input vec_t v,
                                                      input logic [data_w-1:0] data);
      byte_window_u      win;
      logic [addr_w-1:0] off;
      win = '0;
      if (!v.flush) begin
         for (int k = 0; k < int'(access_bytes(v.m_size)); k++) begin
            off = v.m_addr + addr_w'(k) - v.st_addr;     // wraps when below the store
            if (off < addr_w'(access_bytes(v.st_size)))
               win.b[k] = data[8*off[1:0] +: 8];
         end
      end
      return win.w.lo;
   endfunction

   // {no word merge, no dword merge}
   function automatic logic [1:0] merge_hints(input vec_t v);
      logic [addr_w-1:0] st_end;
      logic              st_dual;
      logic              qual;
      st_end  = v.st_addr + addr_w'(access_bytes(v.st_size)) - addr_w'(1);
      st_dual = (v.st_addr[addr_w-1:2] != st_end[addr_w-1:2]);
      qual    = !v.flush && !st_dual;
      return {qual && (v.m_load || v.st_addr[addr_w-1:2] != v.m_addr[addr_w-1:2]),
              qual && (v.m_load || v.st_addr[addr_w-1:3] != v.m_addr[addr_w-1:3])};
   endfunction

   // ******************************
   // drive and compare
   // ******************************
   task automatic compare_word(input string what, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
         row_bad = 1'b1;
      end
   endtask

   task automatic compare_flag(input string what, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
         row_bad = 1'b1;
      end
   endtask

   task automatic drive_idle();
      busreq_m         <= 1'b0;
      valid_m          <= 1'b0;
      load_m           <= 1'b0;
      store_m          <= 1'b0;
      size_m           <= '0;
      addr_m           <= '0;
      is_sideeffects_m <= 1'b0;
      flush_m          <= 1'b0;
      store_data_r     <= '0;
   endtask

   task automatic apply_row(input vec_t v, input int idx);
      logic [data_w-1:0] data;
      logic [1:0]        hints;
      data    = v.rnd ? $urandom : v.st_data;
      hints   = merge_hints(v);
      row_bad = 1'b0;
      @(posedge clk);                        // store enters M
      busreq_m <= 1'b1;
      valid_m  <= 1'b1;
      store_m  <= 1'b1;
      load_m   <= 1'b0;
      size_m   <= v.st_size;
      addr_m   <= v.st_addr;
      flush_m  <= v.flush;
      @(posedge clk);                        // store in R, second access in M
      load_m           <= v.m_load;
      store_m          <= ~v.m_load;
      size_m           <= v.m_size;
      addr_m           <= v.m_addr;
      flush_m          <= 1'b0;
      is_sideeffects_m <= v.side_eff;
      store_data_r     <= data;
      @(negedge clk);
      compare_flag("busreq_r", busreq_r, ~v.flush);
      compare_word("read data", bus_read_data_m, expected_data(v, data));
      compare_flag("full hit", ld_full_hit_m, v.exp_full);
      compare_flag("no word merge", no_word_merge_r, hints[1]);
      compare_flag("no dword merge", no_dword_merge_r, hints[0]);
      @(posedge clk);
      drive_idle();
      $display("test %0d (behavior %0d): %s", idx, v.beh, row_bad ? "mismatch" : "ok");
      if (row_bad)
         bad_tests++;
   endtask

   // ******************************
   // main sequence
   // ******************************
   initial begin
      errors    = 0;
      checks    = 0;
      bad_tests = 0;
      void'($urandom(32'h33a73713));
      arst_n    = 1'b0;
      drive_idle();

      wait_cnt = 0;
      while (wait_cnt < 10) begin            // reset held for 10 cycles
         @(posedge clk);
         wait_cnt++;
      end
      arst_n <= 1'b1;

      row_bad = 1'b0;
      @(negedge clk);
      compare_flag("busreq_r", busreq_r, 1'b0);
      compare_word("read data", bus_read_data_m, '0);
      compare_flag("full hit", ld_full_hit_m, 1'b0);
      compare_flag("no word merge", no_word_merge_r, 1'b0);
      compare_flag("no dword merge", no_dword_merge_r, 1'b0);
      $display("test 0 (behavior 1): %s", row_bad ? "mismatch" : "ok");
      if (row_bad)
         bad_tests++;
      for (int i = 0; i < n_vec; i++)
         apply_row(vectors[i], i + 1);

      $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
               n_vec + 1, bad_tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- source/lsu_fwd_top.sv
/* lsu forwarding front end */

module lsu_fwd_top (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           busreq_m,
   input  logic                           valid_m,
   input  logic                           load_m,
   input  logic                           store_m,
   input  logic [lsu_fwd_pkg::size_w-1:0] size_m,
   input  logic [lsu_fwd_pkg::addr_w-1:0] addr_m,
   input  logic                           is_sideeffects_m,
   input  logic                           flush_m,
   input  logic [lsu_fwd_pkg::data_w-1:0] store_data_r,
   output logic                           busreq_r,
   output logic [lsu_fwd_pkg::data_w-1:0] bus_read_data_m,
   output logic                           ld_full_hit_m,
   output logic                           no_word_merge_r,
   output logic                           no_dword_merge_r
);

   // ******************************
   // stage interfaces
   // ******************************
   lsu_lane_if   lane_if_i ();     // M access lanes
   lsu_rstage_if rstage_if_i ();   // registered R state
   lsu_hit_if    hit_if_i ();      // R to M byte hits

   // ******************************
   // blocks
   // ******************************
   lsu_lane_gen lane_gen_i (
      .size_m (size_m),
      .addr_m (addr_m),
      .lane   (lane_if_i.src)
   );

   lsu_pipe_ctrl pipe_ctrl_i (
      .clk              (clk),
      .arst_n           (arst_n),
      .busreq_m         (busreq_m),
      .valid_m          (valid_m),
      .load_m           (load_m),
      .store_m          (store_m),
      .addr_m           (addr_m),
      .flush_m          (flush_m),
      .lane             (lane_if_i.snk),
      .busreq_r         (busreq_r),
      .no_word_merge_r  (no_word_merge_r),
      .no_dword_merge_r (no_dword_merge_r),
      .rstage           (rstage_if_i.src)
   );

   lsu_fwd_match fwd_match_i (
      .busreq_m (busreq_m),
      .addr_m   (addr_m),
      .lane     (lane_if_i.snk),
      .rstage   (rstage_if_i.snk),
      .hit      (hit_if_i.src)
   );

   lsu_fwd_merge fwd_merge_i (
      .busreq_m         (busreq_m),
      .load_m           (load_m),
      .is_sideeffects_m (is_sideeffects_m),
      .addr_m           (addr_m),
      .store_data_r     (store_data_r),
      .lane             (lane_if_i.snk),
      .rstage           (rstage_if_i.snk),
      .hit              (hit_if_i.snk),
      .bus_read_data_m  (bus_read_data_m),
      .ld_full_hit_m    (ld_full_hit_m)
   );

endmodule

//--- source/lsu_fwd_merge.sv
/* forward data merge and full hit */

module lsu_fwd_merge (
   input  logic                           busreq_m,
   input  logic                           load_m,
   input  logic                           is_sideeffects_m,
   input  logic [lsu_fwd_pkg::addr_w-1:0] addr_m,
   input  logic [lsu_fwd_pkg::data_w-1:0] store_data_r,
   lsu_lane_if.snk                        lane,
   lsu_rstage_if.snk                      rstage,
   lsu_hit_if.snk                         hit,
   output logic [lsu_fwd_pkg::data_w-1:0] bus_read_data_m,
   output logic                           ld_full_hit_m
);
   import lsu_fwd_pkg::*;

   byte_window_u     st_win;      // store data placed on its lanes
   byte_window_u     fwd_win;     // forwarded bytes in M lane order
   byte_window_u     rd_win;      // realigned to the load address
   logic [lanes-1:0] byte_hit_lo;
   logic [lanes-1:0] byte_hit_hi;
   logic             full_hit_lo;
   logic             full_hit_hi;

   // ******************************
   // store data alignment
   // ******************************
   assign st_win = {{data_w{1'b0}}, store_data_r} << {rstage.addr[1:0], 3'b000};

   // ******************************
   // byte mux, lo then hi M word
   // ******************************
   always_comb begin
      fwd_win = '0;                 // unforwarded bytes read as zero
      for (int i = 0; i < lanes; i++) begin
         if (hit.hit_lo_lo[i])
            fwd_win.b[i] = st_win.w.lo[8*i +: 8];
         else if (hit.hit_hi_lo[i])
            fwd_win.b[i] = st_win.w.hi[8*i +: 8];

         if (hit.hit_lo_hi[i])
            fwd_win.b[lanes+i] = st_win.w.lo[8*i +: 8];
         else if (hit.hit_hi_hi[i])
            fwd_win.b[lanes+i] = st_win.w.hi[8*i +: 8];
      end
   end

   // back to load order, first requested byte in bits 7:0
   assign rd_win          = fwd_win >> {addr_m[1:0], 3'b000};
   assign bus_read_data_m = rd_win.w.lo;

   // ******************************
   // full hit
   // ******************************
   assign byte_hit_lo = hit.hit_lo_lo | hit.hit_hi_lo;
   assign byte_hit_hi = hit.hit_lo_hi | hit.hit_hi_hi;

   // every enabled lane must be covered
   assign full_hit_lo = &(byte_hit_lo | ~lane.byteen_lo);
   assign full_hit_hi = &(byte_hit_hi | ~lane.byteen_hi);

   assign ld_full_hit_m = full_hit_lo & full_hit_hi & busreq_m & load_m &
                          ~is_sideeffects_m;   // side-effect loads always go to the bus

endmodule

//--- source/lsu_fwd_match.sv
/* R to M address and byte match */

module lsu_fwd_match (
   input  logic                           busreq_m,
   input  logic [lsu_fwd_pkg::addr_w-1:0] addr_m,
   lsu_lane_if.snk                        lane,
   lsu_rstage_if.snk                      rstage,
   lsu_hit_if.src                         hit
);
   import lsu_fwd_pkg::*;

   logic fwd_qual;
   logic addr_hit_lo_lo;    // R start word vs M start word
   logic addr_hit_lo_hi;    // R start word vs M end word
   logic addr_hit_hi_lo;    // R end word vs M start word
   logic addr_hit_hi_hi;    // R end word vs M end word

   assign fwd_qual = rstage.store_fwd_ok & busreq_m;

   // ******************************
   // word address compares
   // ******************************
   assign addr_hit_lo_lo = fwd_qual &
                           (rstage.addr[addr_w-1:2] == addr_m[addr_w-1:2]);
   assign addr_hit_lo_hi = fwd_qual &
                           (rstage.addr[addr_w-1:2] == lane.end_addr[addr_w-1:2]);
   assign addr_hit_hi_lo = fwd_qual &
                           (rstage.end_addr[addr_w-1:2] == addr_m[addr_w-1:2]);
   assign addr_hit_hi_hi = fwd_qual &
                           (rstage.end_addr[addr_w-1:2] == lane.end_addr[addr_w-1:2]);

   // ******************************
   // per byte hits
   // ******************************

   // lane i of the R word lines up with lane i of the M word
   for (genvar i = 0; i < lanes; i++) begin : g_byte_hit
      assign hit.hit_lo_lo[i] = addr_hit_lo_lo & rstage.byteen_lo[i] & lane.byteen_lo[i];
      assign hit.hit_lo_hi[i] = addr_hit_lo_hi & rstage.byteen_lo[i] & lane.byteen_hi[i];
      assign hit.hit_hi_lo[i] = addr_hit_hi_lo & rstage.byteen_hi[i] & lane.byteen_lo[i];
      assign hit.hit_hi_hi[i] = addr_hit_hi_hi & rstage.byteen_hi[i] & lane.byteen_hi[i];
   end

endmodule

//--- source/lsu_pipe_ctrl.sv
/* R stage registers and merge hints */

module lsu_pipe_ctrl (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           busreq_m,
   input  logic                           valid_m,
   input  logic                           load_m,
   input  logic                           store_m,
   input  logic [lsu_fwd_pkg::addr_w-1:0] addr_m,
   input  logic                           flush_m,
   lsu_lane_if.snk                        lane,
   output logic                           busreq_r,
   output logic                           no_word_merge_r,
   output logic                           no_dword_merge_r,
   lsu_rstage_if.src                      rstage
);
   import lsu_fwd_pkg::*;

   logic              valid_r;
   logic              store_r;
   logic              dual_r;
   logic [addr_w-1:0] addr_r;
   logic [addr_w-1:0] end_addr_r;
   logic [lanes-1:0]  byteen_lo_r;
   logic [lanes-1:0]  byteen_hi_r;

   logic              addr_match_dw;     // same doubleword
   logic              addr_match_word;   // same word
   logic              merge_qual;

   // ******************************
   // M to R pipe register
   // ******************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_r     <= 1'b0;
         store_r     <= 1'b0;
         busreq_r    <= 1'b0;
         dual_r      <= 1'b0;
         addr_r      <= '0;
         end_addr_r  <= '0;
         byteen_lo_r <= '0;
         byteen_hi_r <= '0;
      end else begin
         valid_r     <= valid_m & ~flush_m;    // flushed access enters R dead
         busreq_r    <= busreq_m & ~flush_m;
         store_r     <= store_m;
         dual_r      <= lane.dual;
         addr_r      <= addr_m;
         end_addr_r  <= lane.end_addr;
         byteen_lo_r <= lane.byteen_lo;
         byteen_hi_r <= lane.byteen_hi;
      end
   end

   // forwarding source is only a live store
   assign rstage.store_fwd_ok = valid_r & store_r;
   assign rstage.addr         = addr_r;
   assign rstage.end_addr     = end_addr_r;
   assign rstage.byteen_lo    = byteen_lo_r;
   assign rstage.byteen_hi    = byteen_hi_r;

   // ******************************
   // coalescing hints
   // ******************************
   assign addr_match_dw   = (addr_r[addr_w-1:3] == addr_m[addr_w-1:3]);
   assign addr_match_word = addr_match_dw & (addr_r[2] == addr_m[2]);

   // a dual store in R never coalesces, so no hint is raised for it
   assign merge_qual = busreq_r & ~dual_r & busreq_m;

   assign no_dword_merge_r = merge_qual & (load_m | ~addr_match_dw);
   assign no_word_merge_r  = merge_qual & (load_m | ~addr_match_word);

endmodule

//--- source/lsu_lane_gen.sv
/* M stage byte lane generation */

module lsu_lane_gen (
   input  logic [lsu_fwd_pkg::size_w-1:0] size_m,
   input  logic [lsu_fwd_pkg::addr_w-1:0] addr_m,
   lsu_lane_if.src                        lane
);
   import lsu_fwd_pkg::*;

   logic [lanes-1:0]   byteen;       // enables relative to the access start
   logic [1:0]         end_off;      // bytes minus one
   logic [2*lanes-1:0] byteen_ext;   // enables over the 8-lane window

   // size decode, code 3 is treated like a word
   always_comb begin
      case (size_m)
         size_byte: begin
            byteen  = 4'b0001;
            end_off = 2'd0;
         end
         size_half: begin
            byteen  = 4'b0011;
            end_off = 2'd1;
         end
         size_word: begin
            byteen  = 4'b1111;
            end_off = 2'd3;
         end
         default: begin
            byteen  = 4'b1111;
            end_off = 2'd3;
         end
      endcase
   end

   // ******************************
   // lane window and end address
   // ******************************

   // start lane comes from the low address bits
   assign byteen_ext = {{lanes{1'b0}}, byteen} << addr_m[1:0];

   assign lane.byteen_lo = byteen_ext[lanes-1:0];
   assign lane.byteen_hi = byteen_ext[2*lanes-1:lanes];

   assign lane.end_addr = addr_m + addr_w'(end_off);

   // word select bit flips when the access crosses into the next word
   assign lane.dual = addr_m[2] ^ lane.end_addr[2];

endmodule

//--- source/lsu_stage_if.sv
/* lsu stage interfaces */

// byte lane view of the access sitting in M
interface lsu_lane_if;
   import lsu_fwd_pkg::*;

   logic [addr_w-1:0] end_addr;    // last byte touched
   logic              dual;        // access spans two words
   logic [lanes-1:0]  byteen_lo;
   logic [lanes-1:0]  byteen_hi;

   modport src (output end_addr, dual, byteen_lo, byteen_hi);
   modport snk (input  end_addr, dual, byteen_lo, byteen_hi);
endinterface

// registered R state that a younger load may forward from
interface lsu_rstage_if;
   import lsu_fwd_pkg::*;

   logic              store_fwd_ok;  // valid store in R
   logic [addr_w-1:0] addr;
   logic [addr_w-1:0] end_addr;
   logic [lanes-1:0]  byteen_lo;
   logic [lanes-1:0]  byteen_hi;

   modport src (output store_fwd_ok, addr, end_addr, byteen_lo, byteen_hi);
   modport snk (input  store_fwd_ok, addr, end_addr, byteen_lo, byteen_hi);
endinterface

// per byte hits, R source word first, M destination word second
interface lsu_hit_if;
   import lsu_fwd_pkg::*;

   logic [lanes-1:0] hit_lo_lo, hit_lo_hi, hit_hi_lo, hit_hi_hi;

   modport src (output hit_lo_lo, hit_lo_hi, hit_hi_lo, hit_hi_hi);
   modport snk (input  hit_lo_lo, hit_lo_hi, hit_hi_lo, hit_hi_hi);
endinterface

//--- source/lsu_fwd_pkg.sv
/* lsu forwarding definitions */

package lsu_fwd_pkg;

   // ******************************
   // widths
   // ******************************
   localparam int addr_w = 32;       // byte address
   localparam int data_w = 32;       // one bus data word
   localparam int lanes  = 4;        // byte lanes per word
   localparam int size_w = 2;

   // ******************************
   // access size codes
   // ******************************
   localparam logic [size_w-1:0] size_byte = 2'd0;
   localparam logic [size_w-1:0] size_half = 2'd1;
   localparam logic [size_w-1:0] size_word = 2'd2;

   // ******************************
   // 64-bit shifted byte window
   // ******************************

   // word view, split into the lo and hi lane groups
   typedef struct packed {
      logic [data_w-1:0] hi;
      logic [data_w-1:0] lo;
   } window_words_t;

   // the same window seen as eight bytes, byte 0 in the low bits
   typedef union packed {
      window_words_t            w;
      logic [2*lanes-1:0][7:0]  b;
   } byte_window_u;

endpackage
